// File: rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_mul
    } alu_op_e;

    // primary opcodes
    localparam logic [5:0] op_special  = 6'h00;
    localparam logic [5:0] op_special2 = 6'h1c;
    localparam logic [5:0] op_addiu    = 6'h09;
    localparam logic [5:0] op_slti     = 6'h0a;
    localparam logic [5:0] op_andi     = 6'h0c;
    localparam logic [5:0] op_ori      = 6'h0d;
    localparam logic [5:0] op_xori     = 6'h0e;
    localparam logic [5:0] op_lui      = 6'h0f;

    // function field, special
    localparam logic [5:0] funct_sll  = 6'h00;
    localparam logic [5:0] funct_srl  = 6'h02;
    localparam logic [5:0] funct_sra  = 6'h03;
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_xor  = 6'h26;
    localparam logic [5:0] funct_nor  = 6'h27;
    localparam logic [5:0] funct_slt  = 6'h2a;
    localparam logic [5:0] funct_sltu = 6'h2b;
    localparam logic [5:0] funct_mul  = 6'h02; // under special2

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;   // imm or shamt already folded in
        reg_addr_t dest;
        logic      writes;
    } ds_to_es_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t dest;
        logic      writes;
        word_t     result;
    } es_to_ws_t;

endpackage

// File: rtl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic              aclk,
    input  logic              rst_n,
    input  cpu_pkg::reg_addr_t raddr1,
    output cpu_pkg::word_t     rdata1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata2,
    input  logic              we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);

    cpu_pkg::word_t regs [1:31]; // r0 has no storage

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_waddr_known: assert property (@(posedge aclk) disable iff (!rst_n)
        we |-> !$isunknown(waddr));

endmodule

// File: rtl/id_stage.sv
`timescale 1ns/100ps

module id_stage (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  cpu_pkg::word_t     inst_pc,
    input  cpu_pkg::word_t     inst_word,
    output logic               inst_ready,
    output cpu_pkg::reg_addr_t raddr1,
    output cpu_pkg::reg_addr_t raddr2,
    input  cpu_pkg::word_t     rdata1,
    input  cpu_pkg::word_t     rdata2,
    input  logic               es_fwd_valid,
    input  cpu_pkg::reg_addr_t es_fwd_dest,
    input  cpu_pkg::word_t     es_fwd_result,
    input  logic               es_busy,
    input  logic               ws_fwd_valid,
    input  cpu_pkg::reg_addr_t ws_fwd_dest,
    input  cpu_pkg::word_t     ws_fwd_result,
    output logic               ds_to_es_valid,
    output cpu_pkg::ds_to_es_t ds_to_es_bus,
    input  logic               es_allowin
);

    logic               ds_valid;
    logic               ds_ready_go;
    cpu_pkg::word_t     ds_pc;
    cpu_pkg::word_t     ds_inst;
    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::reg_addr_t dest;
    cpu_pkg::alu_op_e   alu_op;
    logic               known;
    logic               is_rtype;
    logic               is_shift;
    logic               use_imm;
    logic               use_rs;
    logic               use_rt;
    cpu_pkg::word_t     imm_val;
    cpu_pkg::word_t     rs_val;
    cpu_pkg::word_t     rt_val;
    logic               stall;

    assign ds_ready_go    = !stall;
    assign inst_ready     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (inst_ready) begin
            ds_valid <= inst_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_valid && inst_ready) begin
            ds_pc   <= inst_pc;
            ds_inst <= inst_word;
        end
    end

    assign opcode = ds_inst[31:26];
    assign rs     = ds_inst[25:21];
    assign rt     = ds_inst[20:16];
    assign rd     = ds_inst[15:11];
    assign funct  = ds_inst[5:0];

    always_comb begin
        alu_op   = cpu_pkg::alu_add;
        known    = 1'b1;
        is_rtype = 1'b0;
        is_shift = 1'b0;
        use_imm  = 1'b1;
        imm_val  = {16'b0, ds_inst[15:0]}; // zero extension by default
        case (opcode)
            cpu_pkg::op_special: begin
                is_rtype = 1'b1;
                use_imm  = 1'b0;
                case (funct)
                    cpu_pkg::funct_addu: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::funct_subu: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::funct_and:  alu_op = cpu_pkg::alu_and;
                    cpu_pkg::funct_or:   alu_op = cpu_pkg::alu_or;
                    cpu_pkg::funct_xor:  alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::funct_nor:  alu_op = cpu_pkg::alu_nor;
                    cpu_pkg::funct_slt:  alu_op = cpu_pkg::alu_slt;
                    cpu_pkg::funct_sltu: alu_op = cpu_pkg::alu_sltu;
                    cpu_pkg::funct_sll:  alu_op = cpu_pkg::alu_sll;
                    cpu_pkg::funct_srl:  alu_op = cpu_pkg::alu_srl;
                    cpu_pkg::funct_sra:  alu_op = cpu_pkg::alu_sra;
                    default:             known  = 1'b0;
                endcase
                if (alu_op inside {cpu_pkg::alu_sll, cpu_pkg::alu_srl, cpu_pkg::alu_sra}) begin
                    is_shift = 1'b1;
                    use_imm  = 1'b1;
                    imm_val  = {27'b0, ds_inst[10:6]}; // shamt
                end
            end
            cpu_pkg::op_special2: begin
                is_rtype = 1'b1;
                use_imm  = 1'b0;
                alu_op   = cpu_pkg::alu_mul;
                known    = (funct == cpu_pkg::funct_mul);
            end
            cpu_pkg::op_addiu: imm_val = {{16{ds_inst[15]}}, ds_inst[15:0]};
            cpu_pkg::op_slti: begin
                alu_op  = cpu_pkg::alu_slt;
                imm_val = {{16{ds_inst[15]}}, ds_inst[15:0]};
            end
            cpu_pkg::op_andi: alu_op = cpu_pkg::alu_and;
            cpu_pkg::op_ori:  alu_op = cpu_pkg::alu_or;
            cpu_pkg::op_xori: alu_op = cpu_pkg::alu_xor;
            cpu_pkg::op_lui:  alu_op = cpu_pkg::alu_lui; // exe moves it up
            default:          known  = 1'b0;
        endcase
    end

    assign dest   = is_rtype ? rd : rt;
    assign use_rs = known && !is_shift && (alu_op != cpu_pkg::alu_lui);
    assign use_rt = known && (is_shift || !use_imm);

    assign raddr1 = rs;
    assign raddr2 = rt;

    // execute beats result beats register file
    assign rs_val = (rs == '0) ? '0 :
                    (es_fwd_valid && es_fwd_dest == rs) ? es_fwd_result :
                    (ws_fwd_valid && ws_fwd_dest == rs) ? ws_fwd_result : rdata1;
    assign rt_val = (rt == '0) ? '0 :
                    (es_fwd_valid && es_fwd_dest == rt) ? es_fwd_result :
                    (ws_fwd_valid && ws_fwd_dest == rt) ? ws_fwd_result : rdata2;

    // wait out a multiply that will write one of our sources
    assign stall = es_busy && ((use_rs && rs != '0 && es_fwd_dest == rs) ||
                               (use_rt && rt != '0 && es_fwd_dest == rt));

    // operands the op ignores go out as zero
    assign ds_to_es_bus = '{
        pc:     ds_pc,
        alu_op: alu_op,
        src1:   is_shift ? rt_val : (use_rs ? rs_val : '0),
        src2:   use_imm ? imm_val : (use_rt ? rt_val : '0),
        dest:   dest,
        writes: known && (dest != '0)
    };

    a_bus_held: assert property (@(posedge aclk) disable iff (!rst_n)
        ds_to_es_valid && !es_allowin |=> $stable(ds_to_es_bus));

endmodule

// File: rtl/exe_stage.sv
`timescale 1ns/100ps

module exe_stage #(
    parameter int mul_step = 2  // multiplier bits per cycle, 1, 2 or 4
) (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               ds_to_es_valid,
    input  cpu_pkg::ds_to_es_t ds_to_es_bus,
    output logic               es_allowin,
    output logic               es_to_ws_valid,
    output cpu_pkg::es_to_ws_t es_to_ws_bus,
    input  logic               ws_allowin,
    output logic               es_fwd_valid,
    output cpu_pkg::reg_addr_t es_fwd_dest,
    output cpu_pkg::word_t     es_fwd_result,
    output logic               es_busy
);

    logic               es_valid;
    logic               es_done;
    logic               is_mul;
    cpu_pkg::ds_to_es_t es_bus;
    cpu_pkg::word_t     mcand;
    cpu_pkg::word_t     mplier;
    cpu_pkg::word_t     acc;
    cpu_pkg::word_t     mul_pp;
    cpu_pkg::word_t     alu_result;

    assign is_mul         = (es_bus.alu_op == cpu_pkg::alu_mul);
    assign es_allowin     = !es_valid || (es_done && ws_allowin);
    assign es_to_ws_valid = es_valid && es_done;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
            es_done  <= 1'b0;
        end else begin
            if (es_allowin) begin
                es_valid <= ds_to_es_valid;
            end
            if (ds_to_es_valid && es_allowin) begin
                es_done <= 1'b0;
            end else if (es_valid && !es_done) begin
                es_done <= !is_mul || ((mplier >> mul_step) == '0);
            end
        end
    end

    // shift-add, low mul_step bits of the multiplier each cycle
    always_comb begin
        mul_pp = '0;
        for (int i = 0; i < mul_step; i++) begin
            if (mplier[i]) begin
                mul_pp = mul_pp + (mcand << i);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_bus <= ds_to_es_bus;
            mcand  <= ds_to_es_bus.src1;
            mplier <= ds_to_es_bus.src2;
            acc    <= '0;
        end else if (es_valid && !es_done && is_mul) begin
            acc    <= acc + mul_pp;
            mcand  <= mcand << mul_step;
            mplier <= mplier >> mul_step;
        end
    end

    always_comb begin
        case (es_bus.alu_op)
            cpu_pkg::alu_add:  alu_result = es_bus.src1 + es_bus.src2;
            cpu_pkg::alu_sub:  alu_result = es_bus.src1 - es_bus.src2;
            cpu_pkg::alu_and:  alu_result = es_bus.src1 & es_bus.src2;
            cpu_pkg::alu_or:   alu_result = es_bus.src1 | es_bus.src2;
            cpu_pkg::alu_xor:  alu_result = es_bus.src1 ^ es_bus.src2;
            cpu_pkg::alu_nor:  alu_result = ~(es_bus.src1 | es_bus.src2);
            cpu_pkg::alu_slt:
                alu_result = {31'b0, $signed(es_bus.src1) < $signed(es_bus.src2)};
            cpu_pkg::alu_sltu: alu_result = {31'b0, es_bus.src1 < es_bus.src2};
            cpu_pkg::alu_sll:  alu_result = es_bus.src1 << es_bus.src2[4:0];
            cpu_pkg::alu_srl:  alu_result = es_bus.src1 >> es_bus.src2[4:0];
            cpu_pkg::alu_sra:
                alu_result = cpu_pkg::word_t'($signed(es_bus.src1) >>> es_bus.src2[4:0]);
            cpu_pkg::alu_lui:  alu_result = {es_bus.src2[15:0], 16'b0};
            default:           alu_result = acc; // mul
        endcase
    end

    assign es_to_ws_bus = '{
        pc:     es_bus.pc,
        dest:   es_bus.dest,
        writes: es_bus.writes,
        result: alu_result
    };

    // alu results are final on load, mul only once done
    assign es_fwd_valid  = es_valid && es_bus.writes && (!is_mul || es_done);
    assign es_busy       = es_valid && es_bus.writes && is_mul && !es_done;
    assign es_fwd_dest   = es_bus.dest;
    assign es_fwd_result = alu_result;

    a_mul_drained: assert property (@(posedge aclk) disable iff (!rst_n)
        es_to_ws_valid && is_mul |-> mplier == '0);

endmodule

// File: rtl/wb_stage.sv
`timescale 1ns/100ps

module wb_stage (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               es_to_ws_valid,
    input  cpu_pkg::es_to_ws_t es_to_ws_bus,
    output logic               ws_allowin,
    output logic               ws_fwd_valid,
    output cpu_pkg::reg_addr_t ws_fwd_dest,
    output cpu_pkg::word_t     ws_fwd_result,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    logic               ws_valid;
    cpu_pkg::es_to_ws_t ws_bus;

    assign ws_allowin = 1'b1; // retires every cycle

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= es_to_ws_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (es_to_ws_valid && ws_allowin) begin
            ws_bus <= es_to_ws_bus;
        end
    end

    // also the register file write port
    assign ws_fwd_valid  = ws_valid && ws_bus.writes;
    assign ws_fwd_dest   = ws_bus.dest;
    assign ws_fwd_result = ws_bus.result;

    assign debug_wb_pc       = ws_bus.pc;
    assign debug_wb_rf_wen   = {4{ws_fwd_valid}};
    assign debug_wb_rf_wnum  = ws_bus.dest;
    assign debug_wb_rf_wdata = ws_bus.result;

    a_no_r0_trace: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wen != 4'b0 |-> debug_wb_rf_wnum != '0);

endmodule

// File: rtl/cpu_core_top.sv
`timescale 1ns/100ps

module cpu_core_top #(
    parameter int mul_step = 2
) (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  cpu_pkg::word_t     inst_pc,
    input  cpu_pkg::word_t     inst_word,
    output logic               inst_ready,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    cpu_pkg::reg_addr_t raddr1;
    cpu_pkg::reg_addr_t raddr2;
    cpu_pkg::word_t     rdata1;
    cpu_pkg::word_t     rdata2;

    logic               ds_to_es_valid;
    cpu_pkg::ds_to_es_t ds_to_es_bus;
    logic               es_allowin;
    logic               es_to_ws_valid;
    cpu_pkg::es_to_ws_t es_to_ws_bus;
    logic               ws_allowin;

    // forwarding into decode
    logic               es_fwd_valid;
    cpu_pkg::reg_addr_t es_fwd_dest;
    cpu_pkg::word_t     es_fwd_result;
    logic               es_busy;
    logic               ws_fwd_valid;
    cpu_pkg::reg_addr_t ws_fwd_dest;
    cpu_pkg::word_t     ws_fwd_result;

    id_stage id_stage_i (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .inst_valid    (inst_valid),
        .inst_pc       (inst_pc),
        .inst_word     (inst_word),
        .inst_ready    (inst_ready),
        .raddr1        (raddr1),
        .raddr2        (raddr2),
        .rdata1        (rdata1),
        .rdata2        (rdata2),
        .es_fwd_valid  (es_fwd_valid),
        .es_fwd_dest   (es_fwd_dest),
        .es_fwd_result (es_fwd_result),
        .es_busy       (es_busy),
        .ws_fwd_valid  (ws_fwd_valid),
        .ws_fwd_dest   (ws_fwd_dest),
        .ws_fwd_result (ws_fwd_result),
        .ds_to_es_valid(ds_to_es_valid),
        .ds_to_es_bus  (ds_to_es_bus),
        .es_allowin    (es_allowin)
    );

    exe_stage #(.mul_step(mul_step)) exe_stage_i (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .ds_to_es_valid(ds_to_es_valid),
        .ds_to_es_bus  (ds_to_es_bus),
        .es_allowin    (es_allowin),
        .es_to_ws_valid(es_to_ws_valid),
        .es_to_ws_bus  (es_to_ws_bus),
        .ws_allowin    (ws_allowin),
        .es_fwd_valid  (es_fwd_valid),
        .es_fwd_dest   (es_fwd_dest),
        .es_fwd_result (es_fwd_result),
        .es_busy       (es_busy)
    );

    wb_stage wb_stage_i (
        .aclk             (aclk),
        .rst_n            (rst_n),
        .es_to_ws_valid   (es_to_ws_valid),
        .es_to_ws_bus     (es_to_ws_bus),
        .ws_allowin       (ws_allowin),
        .ws_fwd_valid     (ws_fwd_valid),
        .ws_fwd_dest      (ws_fwd_dest),
        .ws_fwd_result    (ws_fwd_result),
        .debug_wb_pc      (debug_wb_pc),
        .debug_wb_rf_wen  (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    reg_file reg_file_i (
        .aclk  (aclk),
        .rst_n (rst_n),
        .raddr1(raddr1),
        .rdata1(rdata1),
        .raddr2(raddr2),
        .rdata2(rdata2),
        .we    (ws_fwd_valid),
        .waddr (ws_fwd_dest),
        .wdata (ws_fwd_result)
    );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter real period       = 4.0,
    parameter int  reset_cycles = 5
) (
    output logic aclk,
    output logic rst_n
);

    initial begin
        aclk = 1'b0;
        forever #(period / 2) aclk = ~aclk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge aclk);
        #(period / 4) rst_n = 1'b1; // released away from both edges
    end

endmodule

// File: bench/tb_top.sv
`timescale 1ns/100ps

module tb_top #(
    parameter int n_inst   = 200,
    parameter int mul_step = 2
);

    localparam real clk_period   = 4.0;
    localparam int  reset_cycles = 5;
    localparam int  drain_cycles = 6;
    localparam int  total_inst   = 31 + 4 * n_inst;
    localparam int  watch_cycles = total_inst * (3 + 32 / mul_step + 4)
                                   + reset_cycles + 5 * drain_cycles + 10;

    localparam logic [5:0] alu_functs [8] = '{
        cpu_pkg::funct_addu, cpu_pkg::funct_subu, cpu_pkg::funct_and, cpu_pkg::funct_or,
        cpu_pkg::funct_xor, cpu_pkg::funct_nor, cpu_pkg::funct_slt, cpu_pkg::funct_sltu
    };
    localparam logic [5:0] shift_functs [3] = '{
        cpu_pkg::funct_sll, cpu_pkg::funct_srl, cpu_pkg::funct_sra
    };
    localparam logic [5:0] imm_ops [6] = '{
        cpu_pkg::op_addiu, cpu_pkg::op_slti, cpu_pkg::op_andi,
        cpu_pkg::op_ori, cpu_pkg::op_xori, cpu_pkg::op_lui
    };

    typedef struct packed {
        cpu_pkg::word_t     pc;
        cpu_pkg::reg_addr_t num;
        cpu_pkg::word_t     data;
    } retire_t;

    logic               aclk;
    logic               rst_n;
    logic               inst_valid;
    cpu_pkg::word_t     inst_pc;
    cpu_pkg::word_t     inst_word;
    logic               inst_ready;
    cpu_pkg::word_t     debug_wb_pc;
    logic [3:0]         debug_wb_rf_wen;
    cpu_pkg::reg_addr_t debug_wb_rf_wnum;
    cpu_pkg::word_t     debug_wb_rf_wdata;

    logic [31:0]    seed = 32'h06cc43fe;
    cpu_pkg::word_t model_regs [32];
    retire_t        exp_q [$];
    cpu_pkg::word_t pc_next = 32'hbfc0_0000;
    logic           pending = 1'b0; // driven but not yet accepted
    string          test_name = "reset_state";
    int             issue_mode = 0;
    int             issue_left = 0;
    int             err_count = 0;
    int             check_count = 0;
    int             pushed = 0;
    int             retired = 0;

    tb_clock #(.period(clk_period), .reset_cycles(reset_cycles)) tb_clock_i (
        .aclk (aclk),
        .rst_n(rst_n)
    );

    cpu_core_top #(.mul_step(mul_step)) cpu_core_top_i (
        .aclk             (aclk),
        .rst_n            (rst_n),
        .inst_valid       (inst_valid),
        .inst_pc          (inst_pc),
        .inst_word        (inst_word),
        .inst_ready       (inst_ready),
        .debug_wb_pc      (debug_wb_pc),
        .debug_wb_rf_wen  (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        return (rand_next() >> 8) % n; // low lcg bits cycle too fast
    endfunction

    function automatic cpu_pkg::reg_addr_t pick_reg(logic narrow);
        if (narrow) begin
            return cpu_pkg::reg_addr_t'(1 + rand_below(3));
        end
        return cpu_pkg::reg_addr_t'(rand_below(32));
    endfunction

    // mode 0 mixed, 1 regs 1..3 only, 2 mul heavy, 3 r0 and unknown heavy
    function automatic cpu_pkg::word_t make_inst(int mode);
        logic               narrow;
        cpu_pkg::reg_addr_t rs;
        cpu_pkg::reg_addr_t rt;
        cpu_pkg::reg_addr_t rd;
        int unsigned        kind;
        narrow = (mode == 1) || (rand_below(4) == 0);
        rs     = pick_reg(narrow);
        rt     = pick_reg(narrow);
        rd     = pick_reg(narrow);
        kind   = rand_below(10);
        if (mode == 2 && rand_below(2) == 0) kind = 9;
        if (mode == 3) begin
            if (rand_below(3) == 0) kind = 8;
            if (rand_below(2) == 0) rs = '0;
            if (rand_below(2) == 0) rt = '0;
            if (rand_below(2) == 0) rd = '0;
        end
        case (kind)
            0, 1, 2, 3:
                return {cpu_pkg::op_special, rs, rt, rd, 5'd0, alu_functs[3'(rand_below(8))]};
            4:
                return {cpu_pkg::op_special, 5'd0, rt, rd, 5'(rand_below(32)),
                        shift_functs[2'(rand_below(3))]};
            5, 6, 7:
                return {imm_ops[3'(rand_below(6))], rs, rt, 16'(rand_next() >> 16)};
            8: begin
                if (rand_below(2) == 0) return {6'h23, rs, rt, 16'h0004}; // lw
                return {cpu_pkg::op_special, rs, 15'd0, 6'h08};            // jr
            end
            default:
                return {cpu_pkg::op_special2, rs, rt, rd, 5'd0, cpu_pkg::funct_mul};
        endcase
    endfunction

    function automatic logic signed_less(cpu_pkg::word_t a, cpu_pkg::word_t b);
        return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    endfunction

    task automatic apply_model(cpu_pkg::word_t pc, cpu_pkg::word_t inst);
        logic [5:0]         op;
        logic [5:0]         fn;
        logic [4:0]         sh;
        cpu_pkg::word_t     a;
        cpu_pkg::word_t     b;
        cpu_pkg::word_t     sext;
        cpu_pkg::word_t     zext;
        cpu_pkg::word_t     res;
        cpu_pkg::reg_addr_t dst;
        logic               known;
        retire_t            entry;
        op    = inst[31:26];
        fn    = inst[5:0];
        sh    = inst[10:6];
        a     = model_regs[inst[25:21]];
        b     = model_regs[inst[20:16]];
        sext  = {{16{inst[15]}}, inst[15:0]};
        zext  = {16'h0, inst[15:0]};
        known = 1'b1;
        res   = '0;
        dst   = (op == cpu_pkg::op_special || op == cpu_pkg::op_special2) ?
                inst[15:11] : inst[20:16];
        if (op == cpu_pkg::op_special) begin
            case (fn)
                cpu_pkg::funct_addu: res = a + b;
                cpu_pkg::funct_subu: res = a - b;
                cpu_pkg::funct_and:  res = a & b;
                cpu_pkg::funct_or:   res = a | b;
                cpu_pkg::funct_xor:  res = a ^ b;
                cpu_pkg::funct_nor:  res = ~(a | b);
                cpu_pkg::funct_slt:  res = {31'b0, signed_less(a, b)};
                cpu_pkg::funct_sltu: res = {31'b0, a < b};
                cpu_pkg::funct_sll:  res = b << sh;
                cpu_pkg::funct_srl:  res = b >> sh;
                cpu_pkg::funct_sra:  res = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
                default:             known = 1'b0;
            endcase
        end else if (op == cpu_pkg::op_special2) begin
            known = (fn == cpu_pkg::funct_mul);
            res   = a * b; // low word only
        end else begin
            case (op)
                cpu_pkg::op_addiu: res = a + sext;
                cpu_pkg::op_slti:  res = {31'b0, signed_less(a, sext)};
                cpu_pkg::op_andi:  res = a & zext;
                cpu_pkg::op_ori:   res = a | zext;
                cpu_pkg::op_xori:  res = a ^ zext;
                cpu_pkg::op_lui:   res = {inst[15:0], 16'h0};
                default:           known = 1'b0;
            endcase
        end
        if (known && dst != '0) begin
            model_regs[dst] = res;
            entry.pc   = pc;
            entry.num  = dst;
            entry.data = res;
            exp_q.push_back(entry);
            pushed++;
        end
    endtask

    task automatic compare_word(string what, cpu_pkg::word_t exp, cpu_pkg::word_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_reg(string what, cpu_pkg::reg_addr_t exp, cpu_pkg::reg_addr_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERROR %s %s: expected r%0d, actual r%0d", test_name, what, exp, act);
        end
    endtask

    task automatic compare_wen(string what, logic [3:0] exp, logic [3:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_retire();
        retire_t entry;
        if (debug_wb_rf_wen == 4'b0) return;
        compare_wen("wen", 4'hf, debug_wb_rf_wen);
        retired++;
        if (exp_q.size() == 0) begin
            err_count++;
            $display("%s: write of r%0d at pc %h retired with no instruction outstanding",
                     test_name, debug_wb_rf_wnum, debug_wb_pc);
            return;
        end
        entry = exp_q.pop_front();
        compare_word("pc", entry.pc, debug_wb_pc);
        compare_reg("wnum", entry.num, debug_wb_rf_wnum);
        compare_word("wdata", entry.data, debug_wb_rf_wdata);
    endtask

    // trace first, then the next input; both at the falling edge
    task automatic run_cycle();
        cpu_pkg::reg_addr_t r;
        @(negedge aclk);
        check_retire();
        if (pending) begin
            if (inst_ready) begin
                apply_model(inst_pc, inst_word);
                pending = 1'b0;
            end
        end else if (issue_left > 0 && rand_below(4) != 0) begin
            r          = cpu_pkg::reg_addr_t'(32 - issue_left);
            inst_valid = 1'b1;
            inst_pc    = pc_next;
            inst_word  = (issue_mode == 4) ?
                         {cpu_pkg::op_special, r, 5'd0, r, 5'd0, cpu_pkg::funct_addu} :
                         make_inst(issue_mode);
            pc_next    = pc_next + 32'd4;
            issue_left--;
            if (inst_ready) apply_model(inst_pc, inst_word);
            else pending = 1'b1;
        end else begin
            inst_valid = 1'b0;
        end
    endtask

    task automatic run_test(string name, int mode, int count);
        int errs_before;
        errs_before = err_count;
        test_name   = name;
        issue_mode  = mode;
        issue_left  = count;
        while (issue_left > 0 || pending || exp_q.size() != 0) run_cycle();
        repeat (drain_cycles) run_cycle(); // catches stray trace entries
        $display("test %s: %0d instructions, %0d errors", name, count, err_count - errs_before);
    endtask

    initial begin
        inst_valid = 1'b0;
        inst_pc    = '0;
        inst_word  = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        while (rst_n !== 1'b1) begin
            @(negedge aclk);
            compare_wen("wen in reset", 4'h0, debug_wb_rf_wen);
        end
        run_test("reset_state", 4, 31); // addu ri, ri, r0 reads every register once
        run_test("alu_ops", 0, n_inst);
        run_test("forwarding", 1, n_inst);
        run_test("mul_backpressure", 2, n_inst);
        run_test("zero_register", 3, n_inst);
        if (exp_q.size() != 0 || retired != pushed) begin
            err_count++;
            $display("order_and_count: %0d of %0d expected writes retired, %0d outstanding",
                     retired, pushed, exp_q.size());
        end
        $display("test order_and_count: %0d of %0d writes retired", retired, pushed);
        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(real'(watch_cycles) * clk_period);
        $display("watchdog: pipeline stopped retiring, run did not finish in %0d cycles",
                 watch_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: list.f
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/id_stage.sv
rtl/exe_stage.sv
rtl/wb_stage.sv
rtl/cpu_core_top.sv
bench/tb_clock.sv
bench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
N_INST    ?= 200
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) --binary --assert -f list.f --top-module $(TOP) \
		-Gn_inst=$(N_INST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "check: failure reported in $(LOG)"; \
		exit 1; \
	fi
	@echo "check: $(LOG) is clean"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
